//--- hdl/execConfig_config.svh
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// ######################################################################
// datapath widths.
// ######################################################################

`define DATA_WIDTH 32
`define ADDR_WIDTH 32
`define NAME_WIDTH 5

// ######################################################################
// tomasulo structure sizes.
// ######################################################################

// tags index the reorder buffer directly.
`define TAG_WIDTH 3
`define ROB_DEPTH 8
`define RS_DEPTH 4

// register block bus.
`define APB_ADDR_WIDTH 4

`endif

//--- hdl/execPkg.sv
`include "execConfig_config.svh"

package execPkg;

    // integer operations, including the jump and upper-immediate forms.
    typedef enum logic [3:0] {
        ADD   = 4'd0,
        SUB   = 4'd1,
        SLL   = 4'd2,
        SLT   = 4'd3,
        SLTU  = 4'd4,
        XOR   = 4'd5,
        SRL   = 4'd6,
        SRA   = 4'd7,
        OR    = 4'd8,
        AND   = 4'd9,
        LUI   = 4'd10,
        AUIPC = 4'd11,
        JAL   = 4'd12,
        JALR  = 4'd13
    } aluOpE;

    // a source operand is either a value or the tag of its producer.
    typedef struct packed {
        logic                   ready;
        logic [`TAG_WIDTH-1:0]  tag;
        logic [`DATA_WIDTH-1:0] data;
    } operandT;

    typedef struct packed {
        aluOpE                  opCode;
        operandT                srcO;
        operandT                srcT;
        logic [`NAME_WIDTH-1:0] name;
        logic [`ADDR_WIDTH-1:0] pc;
    } dispatchT;

    typedef struct packed {
        aluOpE                  opCode;
        logic [`DATA_WIDTH-1:0] operandO;
        logic [`DATA_WIDTH-1:0] operandT;
        logic [`ADDR_WIDTH-1:0] pc;
        logic [`TAG_WIDTH-1:0]  tag;
    } issueT;

    typedef struct packed {
        logic                   valid;
        logic [`TAG_WIDTH-1:0]  tag;
        logic [`DATA_WIDTH-1:0] data;
        logic                   jumpEn;
        logic [`ADDR_WIDTH-1:0] jumpAddr;
    } cdbT;

    typedef struct packed {
        logic                   valid;
        logic [`NAME_WIDTH-1:0] name;
        logic [`DATA_WIDTH-1:0] data;
        logic                   jumpEn;
        logic [`ADDR_WIDTH-1:0] jumpAddr;
    } commitT;

endpackage

//--- hdl/aluRs.sv
`timescale 1ns/1ps
`include "execConfig_config.svh"

module aluRs (
    input  logic                  clk,
    input  logic                  rstN,
    input  execPkg::dispatchT     dispatch,
    input  logic                  dispatchFire,
    input  logic [`TAG_WIDTH-1:0] allocTag,
    input  execPkg::operandT      lookupO,
    input  execPkg::operandT      lookupT,
    input  execPkg::cdbT          cdb,
    input  logic                  issueEn,
    output logic                  free,
    output execPkg::issueT        issue,
    output logic                  issueValid
);

    localparam int IDX_WIDTH = $clog2(`RS_DEPTH);

    logic                   valid  [`RS_DEPTH];
    execPkg::aluOpE         opCode [`RS_DEPTH];
    execPkg::operandT       srcO   [`RS_DEPTH];
    execPkg::operandT       srcT   [`RS_DEPTH];
    logic [`ADDR_WIDTH-1:0] pc     [`RS_DEPTH];
    logic [`TAG_WIDTH-1:0]  tag    [`RS_DEPTH];
    // larger age means older; ages stay packed in 0..count-1.
    logic [IDX_WIDTH-1:0]   age    [`RS_DEPTH];

    logic [IDX_WIDTH-1:0] freeIdx;
    logic [IDX_WIDTH-1:0] issueIdx;
    logic [IDX_WIDTH-1:0] bestAge;
    logic                 anyReady;
    execPkg::operandT     newO;
    execPkg::operandT     newT;

    // a waiting operand picks up a matching bus result.
    function automatic execPkg::operandT snoop(input execPkg::operandT op,
                                               input execPkg::cdbT bus);
        execPkg::operandT res;
        res = op;
        if (!op.ready && bus.valid && bus.tag == op.tag) begin
            res.ready = 1'b1;
            res.data  = bus.data;
        end
        return res;
    endfunction

    // value first, then the buffer's stored result, then the live bus.
    function automatic execPkg::operandT resolve(input execPkg::operandT src,
                                                 input execPkg::operandT lookup,
                                                 input execPkg::cdbT bus);
        execPkg::operandT res;
        res = src;
        if (!src.ready && lookup.ready) begin
            res.ready = 1'b1;
            res.data  = lookup.data;
        end else begin
            res = snoop(src, bus);
        end
        return res;
    endfunction

    assign newO = resolve(dispatch.srcO, lookupO, cdb);
    assign newT = resolve(dispatch.srcT, lookupT, cdb);

    always_comb begin
        free    = 1'b0;
        freeIdx = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                free    = 1'b1;
                freeIdx = IDX_WIDTH'(i);
            end
        end
    end

    // oldest ready entry wins.
    always_comb begin
        anyReady = 1'b0;
        issueIdx = '0;
        bestAge  = '0;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (valid[i] && srcO[i].ready && srcT[i].ready &&
                (!anyReady || age[i] > bestAge)) begin
                anyReady = 1'b1;
                issueIdx = IDX_WIDTH'(i);
                bestAge  = age[i];
            end
        end
    end

    assign issueValid      = anyReady && issueEn;
    assign issue.opCode    = opCode[issueIdx];
    assign issue.operandO  = srcO[issueIdx].data;
    assign issue.operandT  = srcT[issueIdx].data;
    assign issue.pc        = pc[issueIdx];
    assign issue.tag       = tag[issueIdx];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `RS_DEPTH; i++) begin
                valid[i] <= 1'b0;
                age[i]   <= '0;
            end
        end else begin
            for (int i = 0; i < `RS_DEPTH; i++) begin
                if (valid[i]) begin
                    srcO[i] <= snoop(srcO[i], cdb);
                    srcT[i] <= snoop(srcT[i], cdb);
                    if (issueValid && issueIdx == IDX_WIDTH'(i)) begin
                        valid[i] <= 1'b0;
                    end else begin
                        age[i] <= age[i] + IDX_WIDTH'(dispatchFire)
                                  - IDX_WIDTH'(issueValid && age[i] > bestAge);
                    end
                end
            end
            if (dispatchFire) begin
                valid[freeIdx]  <= 1'b1;
                opCode[freeIdx] <= dispatch.opCode;
                srcO[freeIdx]   <= newO;
                srcT[freeIdx]   <= newT;
                pc[freeIdx]     <= dispatch.pc;
                tag[freeIdx]    <= allocTag;
                age[freeIdx]    <= '0;
            end
        end
    end

    fireHasSlot: assert property (@(posedge clk) disable iff (!rstN)
        dispatchFire |-> free);

    // no entry leaves the station while issue is held off.
    issueGated: assert property (@(posedge clk) disable iff (!rstN)
        !issueEn |=> !$rose(free));

endmodule

//--- hdl/alu.sv
`timescale 1ns/1ps
`include "execConfig_config.svh"

module alu (
    input  logic           clk,
    input  logic           rstN,
    input  execPkg::issueT issue,
    input  logic           issueValid,
    output execPkg::cdbT   cdb
);

    logic [`DATA_WIDTH-1:0] result;
    logic                   isJump;
    logic [`ADDR_WIDTH-1:0] target;
    logic [`ADDR_WIDTH-1:0] linkAddr;
    logic [4:0]             shamt;

    assign shamt    = issue.operandT[4:0];
    assign linkAddr = issue.pc + `ADDR_WIDTH'(4);

    always_comb begin
        result = '0;
        isJump = 1'b0;
        target = '0;
        case (issue.opCode)
            execPkg::ADD:   result = issue.operandO + issue.operandT;
            execPkg::SUB:   result = issue.operandO - issue.operandT;
            execPkg::SLL:   result = issue.operandO << shamt;
            execPkg::SLT:   result = `DATA_WIDTH'($signed(issue.operandO) <
                                                  $signed(issue.operandT));
            execPkg::SLTU:  result = `DATA_WIDTH'(issue.operandO < issue.operandT);
            execPkg::XOR:   result = issue.operandO ^ issue.operandT;
            execPkg::SRL:   result = issue.operandO >> shamt;
            execPkg::SRA:   result = $unsigned($signed(issue.operandO) >>> shamt);
            execPkg::OR:    result = issue.operandO | issue.operandT;
            execPkg::AND:   result = issue.operandO & issue.operandT;
            execPkg::LUI:   result = issue.operandT;
            execPkg::AUIPC: result = `DATA_WIDTH'(issue.pc) + issue.operandT;
            execPkg::JAL: begin
                isJump = 1'b1;
                target = issue.pc + `ADDR_WIDTH'(issue.operandT);
                result = `DATA_WIDTH'(linkAddr);
            end
            execPkg::JALR: begin
                // target is forced to an even address.
                isJump = 1'b1;
                target = `ADDR_WIDTH'(issue.operandO + issue.operandT) & ~`ADDR_WIDTH'(1);
                result = `DATA_WIDTH'(linkAddr);
            end
            default: ;
        endcase
    end

    // one op per cycle, result lands on the bus the cycle after issue.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid    <= issueValid;
            cdb.tag      <= issue.tag;
            cdb.data     <= result;
            cdb.jumpEn   <= isJump;
            cdb.jumpAddr <= target;
        end
    end

endmodule

//--- hdl/reorderBuffer.sv
`timescale 1ns/1ps
`include "execConfig_config.svh"

module reorderBuffer (
    input  logic                  clk,
    input  logic                  rstN,
    input  execPkg::dispatchT     dispatch,
    input  logic                  dispatchFire,
    input  execPkg::cdbT          cdb,
    output logic [`TAG_WIDTH-1:0] allocTag,
    output logic                  full,
    output execPkg::operandT      lookupO,
    output execPkg::operandT      lookupT,
    output execPkg::commitT       commit
);

    localparam logic [`TAG_WIDTH:0] DEPTH_COUNT = `ROB_DEPTH;

    // ######################################################################
    // entry storage.
    // ######################################################################

    logic                   busy     [`ROB_DEPTH];
    logic                   done     [`ROB_DEPTH];
    logic [`NAME_WIDTH-1:0] name     [`ROB_DEPTH];
    logic [`DATA_WIDTH-1:0] data     [`ROB_DEPTH];
    logic                   jumpEn   [`ROB_DEPTH];
    logic [`ADDR_WIDTH-1:0] jumpAddr [`ROB_DEPTH];

    logic [`TAG_WIDTH-1:0]  head;
    logic [`TAG_WIDTH-1:0]  tail;
    logic [`TAG_WIDTH:0]    count;
    logic                   retire;

    assign allocTag = tail;
    assign full     = count == DEPTH_COUNT;
    assign retire   = busy[head] && done[head];

    // done stays set after retirement until the slot is handed out again.
    always_comb begin
        lookupO.tag   = dispatch.srcO.tag;
        lookupO.ready = done[dispatch.srcO.tag];
        lookupO.data  = data[dispatch.srcO.tag];
        lookupT.tag   = dispatch.srcT.tag;
        lookupT.ready = done[dispatch.srcT.tag];
        lookupT.data  = data[dispatch.srcT.tag];
    end

    // ######################################################################
    // allocate, complete, retire.
    // ######################################################################

    always_ff @(posedge clk) begin
        if (!rstN) begin
            head          <= '0;
            tail          <= '0;
            count         <= '0;
            commit.valid  <= 1'b0;
            commit.jumpEn <= 1'b0;
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                busy[i] <= 1'b0;
                done[i] <= 1'b0;
            end
        end else begin
            commit.valid  <= retire;
            commit.jumpEn <= retire && jumpEn[head];
            if (retire) begin
                commit.name     <= name[head];
                commit.data     <= data[head];
                commit.jumpAddr <= jumpAddr[head];
                busy[head]      <= 1'b0;
                head            <= head + 1'b1;
            end
            if (cdb.valid) begin
                done[cdb.tag]     <= 1'b1;
                data[cdb.tag]     <= cdb.data;
                jumpEn[cdb.tag]   <= cdb.jumpEn;
                jumpAddr[cdb.tag] <= cdb.jumpAddr;
            end
            if (dispatchFire) begin
                busy[tail] <= 1'b1;
                done[tail] <= 1'b0;
                name[tail] <= dispatch.name;
                tail       <= tail + 1'b1;
            end
            count <= count + (`TAG_WIDTH + 1)'(dispatchFire)
                     - (`TAG_WIDTH + 1)'(retire);
        end
    end

    // a bus result always belongs to an op that is still in flight.
    cdbHitsBusy: assert property (@(posedge clk) disable iff (!rstN)
        cdb.valid |-> busy[cdb.tag]);

endmodule

//--- hdl/execRegs.sv
`timescale 1ns/1ps
`include "execConfig_config.svh"

module execRegs (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [`APB_ADDR_WIDTH-1:0] paddr,
    input  logic [`DATA_WIDTH-1:0]     pwdata,
    input  execPkg::commitT            commit,
    output logic [`DATA_WIDTH-1:0]     prdata,
    output logic                       pready,
    output logic                       pslverr,
    output logic                       issueEn
);

    localparam logic [`APB_ADDR_WIDTH-1:0] CTRL_ADDR     = 'h0;
    localparam logic [`APB_ADDR_WIDTH-1:0] COMMITS_ADDR  = 'h4;
    localparam logic [`APB_ADDR_WIDTH-1:0] LASTJUMP_ADDR = 'h8;

    logic                   access;
    logic                   addrHit;
    logic                   readOnly;
    logic [31:0]            commitCount;
    logic [`ADDR_WIDTH-1:0] lastJump;

    assign access = psel && penable;
    assign pready = 1'b1;

    always_comb begin
        addrHit  = 1'b1;
        readOnly = 1'b1;
        prdata   = '0;
        case (paddr)
            CTRL_ADDR: begin
                readOnly = 1'b0;
                prdata   = `DATA_WIDTH'(issueEn);
            end
            COMMITS_ADDR:  prdata = `DATA_WIDTH'(commitCount);
            LASTJUMP_ADDR: prdata = `DATA_WIDTH'(lastJump);
            default:       addrHit = 1'b0;
        endcase
    end

    // bad address or write to a status register.
    assign pslverr = access && (!addrHit || (pwrite && readOnly));

    always_ff @(posedge clk) begin
        if (!rstN) begin
            issueEn     <= 1'b0;
            commitCount <= '0;
            lastJump    <= '0;
        end else begin
            if (access && pwrite && paddr == CTRL_ADDR) begin
                issueEn <= pwdata[0];
            end
            if (commit.valid) begin
                commitCount <= commitCount + 32'd1;
            end
            if (commit.jumpEn) begin
                lastJump <= commit.jumpAddr;
            end
        end
    end

endmodule

//--- hdl/execCore.sv
`timescale 1ns/1ps
`include "execConfig_config.svh"

module execCore (
    input  logic                       clk,
    input  logic                       rstN,
    input  execPkg::dispatchT          dispatch,
    input  logic                       dispatchValid,
    output logic                       dispatchReady,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [`APB_ADDR_WIDTH-1:0] paddr,
    input  logic [`DATA_WIDTH-1:0]     pwdata,
    output logic [`DATA_WIDTH-1:0]     prdata,
    output logic                       pready,
    output logic                       pslverr,
    output execPkg::commitT            commit
);

    logic                  dispatchFire;
    logic                  rsFree;
    logic                  robFull;
    logic [`TAG_WIDTH-1:0] allocTag;
    logic                  issueEn;
    logic                  issueValid;
    execPkg::operandT      lookupO;
    execPkg::operandT      lookupT;
    execPkg::issueT        issue;
    execPkg::cdbT          cdb;

    // a dispatch needs a station slot and a buffer entry at once.
    assign dispatchReady = rsFree && !robFull;
    assign dispatchFire  = dispatchValid && dispatchReady;

    aluRs u_aluRs (
        .clk, .rstN, .dispatch, .dispatchFire, .allocTag,
        .lookupO, .lookupT, .cdb, .issueEn,
        .free(rsFree), .issue, .issueValid
    );

    alu u_alu (
        .clk, .rstN, .issue, .issueValid, .cdb
    );

    reorderBuffer u_reorderBuffer (
        .clk, .rstN, .dispatch, .dispatchFire, .cdb,
        .allocTag, .full(robFull), .lookupO, .lookupT, .commit
    );

    execRegs u_execRegs (
        .clk, .rstN, .psel, .penable, .pwrite, .paddr, .pwdata, .commit,
        .prdata, .pready, .pslverr, .issueEn
    );

endmodule

//--- tb/execCoreTb.sv
`timescale 1ns/1ps
`include "execConfig_config.svh"

module execCoreTb;

    localparam int CLK_PERIOD = 40;
    localparam int WAIT_LIMIT = 500;
    localparam int NUM_ROWS   = 23;
    localparam int GATE_ROWS  = `RS_DEPTH;

    // mode 0 takes the literal, -1 a random value, k > 0 the result of the op k dispatches back.
    typedef struct packed {
        execPkg::aluOpE         op;
        int                     modeO;
        logic [`DATA_WIDTH-1:0] valO;
        int                     modeT;
        logic [`DATA_WIDTH-1:0] valT;
        logic [`ADDR_WIDTH-1:0] pc;
    } rowT;

    logic                       clk;
    logic                       rstN;
    execPkg::dispatchT          dispatch;
    logic                       dispatchValid;
    logic                       dispatchReady;
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [`APB_ADDR_WIDTH-1:0] paddr;
    logic [`DATA_WIDTH-1:0]     pwdata;
    logic [`DATA_WIDTH-1:0]     prdata;
    logic                       pready;
    logic                       pslverr;
    execPkg::commitT            commit;

    rowT                    rows [NUM_ROWS];
    logic [`DATA_WIDTH-1:0] results [64];
    execPkg::commitT        expQ [$];
    logic [31:0]            rngState;
    logic [`ADDR_WIDTH-1:0] lastJumpExp;
    int                     dispCount;

    execCore u_execCore (
        .clk, .rstN, .dispatch, .dispatchValid, .dispatchReady,
        .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
        .commit
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ######################################################################
    // helpers.
    // ######################################################################

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            abortRun($sformatf("mismatch at %0t: %s got %h expected %h",
                               $time, name, got, exp));
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // expected result of one op, straight from the integer rules.
    function automatic execPkg::commitT model(input execPkg::aluOpE op,
                                              input logic [31:0] a, input logic [31:0] b,
                                              input logic [31:0] pc);
        execPkg::commitT e;
        logic [4:0] sh;
        e = '0;
        e.valid = 1'b1;
        sh = b[4:0];
        case (op)
            execPkg::ADD:   e.data = a + b;
            execPkg::SUB:   e.data = a - b;
            execPkg::SLL:   e.data = a << sh;
            execPkg::SLT:   e.data = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            execPkg::SLTU:  e.data = {31'd0, a < b};
            execPkg::XOR:   e.data = a ^ b;
            execPkg::SRL:   e.data = a >> sh;
            execPkg::SRA:   e.data = (a >> sh) | (a[31] ? ~(32'hffffffff >> sh) : 32'd0);
            execPkg::OR:    e.data = a | b;
            execPkg::AND:   e.data = a & b;
            execPkg::LUI:   e.data = b;
            execPkg::AUIPC: e.data = pc + b;
            execPkg::JAL: begin
                e.data     = pc + 32'd4;
                e.jumpEn   = 1'b1;
                e.jumpAddr = pc + b;
            end
            default: begin
                e.data     = pc + 32'd4;
                e.jumpEn   = 1'b1;
                e.jumpAddr = (a + b) & 32'hfffffffe;
            end
        endcase
        return e;
    endfunction

    task automatic makeOperand(input int mode, input logic [31:0] lit,
                               output execPkg::operandT o, output logic [31:0] val);
        int pIdx;
        o = '0;
        if (mode > 0) begin
            pIdx  = dispCount - mode;
            o.tag = `TAG_WIDTH'(pIdx);
            val   = results[pIdx];
        end else begin
            if (mode < 0) begin
                rngState = xorshift(rngState);
                val      = rngState;
            end else begin
                val = lit;
            end
            o.ready = 1'b1;
            o.data  = val;
        end
    endtask

    // called on a falling edge, returns on the falling edge after the transfer.
    task automatic sendRow(input rowT r);
        execPkg::dispatchT d;
        execPkg::commitT   e;
        logic [31:0]       a;
        logic [31:0]       b;
        int                waitCount;
        d = '0;
        makeOperand(r.modeO, r.valO, d.srcO, a);
        makeOperand(r.modeT, r.valT, d.srcT, b);
        d.opCode = r.op;
        d.pc     = r.pc;
        d.name   = `NAME_WIDTH'(dispCount % 31 + 1);
        e        = model(r.op, a, b, r.pc);
        e.name   = d.name;
        results[dispCount] = e.data;
        if (e.jumpEn) begin
            lastJumpExp = e.jumpAddr;
        end
        expQ.push_back(e);
        dispCount++;
        dispatch      = d;
        dispatchValid = 1'b1;
        waitCount     = 0;
        while (!dispatchReady) begin
            if (waitCount == WAIT_LIMIT) begin
                abortRun("timeout: dispatchReady never came back high");
            end
            @(negedge clk);
            waitCount++;
        end
        @(negedge clk);
        dispatchValid = 1'b0;
    endtask

    task automatic apbAccess(input logic wr, input logic [`APB_ADDR_WIDTH-1:0] addr,
                             input logic [31:0] wdata, input logic expErr,
                             output logic [31:0] rdata);
        int waitCount;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable   = 1'b1;
        waitCount = 0;
        #(CLK_PERIOD / 4);
        while (!pready) begin
            if (waitCount == WAIT_LIMIT) begin
                abortRun("timeout: APB slave never raised pready");
            end
            @(negedge clk);
            #(CLK_PERIOD / 4);
            waitCount++;
        end
        rdata = prdata;
        checkValue("pslverr", pslverr, expErr);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apbWrite(input logic [`APB_ADDR_WIDTH-1:0] addr, input logic [31:0] data,
                            input logic expErr);
        logic [31:0] unused;
        apbAccess(1'b1, addr, data, expErr, unused);
    endtask

    task automatic apbRead(input logic [`APB_ADDR_WIDTH-1:0] addr, input logic [31:0] exp,
                           input logic expErr, input string name);
        logic [31:0] rdata;
        apbAccess(1'b0, addr, 32'd0, expErr, rdata);
        if (!expErr) begin
            checkValue(name, rdata, exp);
        end
    endtask

    task automatic waitForCommits();
        int waitCount;
        waitCount = 0;
        while (expQ.size() != 0) begin
            if (waitCount == WAIT_LIMIT) begin
                abortRun("timeout: dispatched ops never all committed");
            end
            @(negedge clk);
            waitCount++;
        end
    endtask

    // commit records are registered, so the falling edge sees them settled.
    always @(negedge clk) begin
        execPkg::commitT e;
        if (rstN === 1'b1 && commit.valid === 1'b1) begin
            if (expQ.size() == 0) begin
                abortRun("a commit record appeared with no op outstanding");
            end else begin
                e = expQ.pop_front();
                checkValue("commit.name", commit.name, e.name);
                checkValue("commit.data", commit.data, e.data);
                checkValue("commit.jumpEn", commit.jumpEn, e.jumpEn);
                if (e.jumpEn) begin
                    checkValue("commit.jumpAddr", commit.jumpAddr, e.jumpAddr);
                end
            end
        end
    end

    // ######################################################################
    // stimulus.
    // ######################################################################

    initial begin
        rows = '{
            '{execPkg::ADD,   0, 32'd7,        0, 32'd9,        32'h100},
            '{execPkg::SUB,   0, 32'd5,        0, 32'd20,       32'h104},
            '{execPkg::XOR,  -1, 32'd0,       -1, 32'd0,        32'h108},
            '{execPkg::OR,   -1, 32'd0,        0, 32'h0f0,      32'h10c},
            '{execPkg::SLL,   0, 32'd1,        0, 32'd35,       32'h110},
            '{execPkg::SRL,   0, 32'h80000000, 0, 32'd33,       32'h114},
            '{execPkg::SRA,   0, 32'h80000000, 0, 32'd63,       32'h118},
            '{execPkg::SLT,   0, 32'hffffffff, 0, 32'd1,        32'h11c},
            '{execPkg::SLTU,  0, 32'hffffffff, 0, 32'd1,        32'h120},
            '{execPkg::AND,  -1, 32'd0,       -1, 32'd0,        32'h124},
            '{execPkg::LUI,   0, 32'd0,        0, 32'h12345000, 32'h128},
            '{execPkg::AUIPC, 0, 32'd0,        0, 32'h1000,     32'h200},
            '{execPkg::JAL,   0, 32'd0,        0, 32'h40,       32'h300},
            '{execPkg::JALR,  0, 32'h1001,     0, 32'd4,        32'h400},
            '{execPkg::ADD,   1, 32'd0,        0, 32'h10,       32'h404},
            '{execPkg::SUB,   1, 32'd0,        2, 32'd0,        32'h408},
            '{execPkg::SLL,   3, 32'd0,        0, 32'd4,        32'h40c},
            '{execPkg::XOR,   1, 32'd0,        3, 32'd0,        32'h410},
            '{execPkg::ADD,   4, 32'd0,        7, 32'd0,        32'h414},
            '{execPkg::SRA,   1, 32'd0,       -1, 32'd0,        32'h418},
            '{execPkg::JALR,  2, 32'd0,        0, 32'd3,        32'h500},
            '{execPkg::AND,   1, 32'd0,        1, 32'd0,        32'h504},
            '{execPkg::JAL,   0, 32'd0,        0, 32'hfffffff0, 32'h600}
        };
        rstN          = 1'b0;
        dispatch      = '0;
        dispatchValid = 1'b0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        rngState      = 32'h7cc6;
        lastJumpExp   = '0;
        dispCount     = 0;
        repeat (10) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);
        checkValue("dispatchReady", dispatchReady, 32'd1);

        // register block after reset and its error responses.
        apbRead(4'h0, 32'd0, 1'b0, "CTRL");
        apbRead(4'h4, 32'd0, 1'b0, "COMMITS");
        apbRead(4'h8, 32'd0, 1'b0, "LASTJUMP");
        apbWrite(4'h0, 32'hfffffffe, 1'b0);
        apbRead(4'h0, 32'd0, 1'b0, "CTRL");
        apbRead(4'hc, 32'd0, 1'b1, "unmapped");
        apbWrite(4'h4, 32'h55, 1'b1);
        apbRead(4'h4, 32'd0, 1'b0, "COMMITS");

        // fill the station with issue held off.
        for (int i = 0; i < GATE_ROWS; i++) begin
            sendRow(rows[i]);
        end
        checkValue("dispatchReady", dispatchReady, 32'd0);
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            checkValue("commit.valid", commit.valid, 32'd0);
        end
        apbWrite(4'h0, 32'd1, 1'b0);
        waitForCommits();
        apbRead(4'h0, 32'd1, 1'b0, "CTRL");

        // all operations, dependency chains and jumps back to back.
        for (int i = GATE_ROWS; i < NUM_ROWS; i++) begin
            sendRow(rows[i]);
        end
        waitForCommits();
        apbRead(4'h8, lastJumpExp, 1'b0, "LASTJUMP");
        apbRead(4'h4, 32'(dispCount), 1'b0, "COMMITS");

        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- files.f
+incdir+hdl
hdl/execPkg.sv
hdl/aluRs.sv
hdl/alu.sv
hdl/reorderBuffer.sv
hdl/execRegs.sv
hdl/execCore.sv
tb/execCoreTb.sv

//--- run.sh
#!/bin/sh
# build and run the testbench, then decide the outcome from the log.
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module execCoreTb -o execCoreSim \
    && ./obj_dir/execCoreSim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "PASS: all tests" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
